/* dv/frv_writeback_ref.svh */
// ----------------------------------------------------------
// Reference model of the back end. Shadow GPR and CSR state,
// advanced once per retired instruction in issue order.
// ----------------------------------------------------------
`ifndef FRV_WRITEBACK_REF_SVH
`define FRV_WRITEBACK_REF_SVH

typedef struct packed {
    logic        irq;                               // Interrupt level at transfer
    issue_t      ins;
} issued_t;

typedef struct packed {
    logic        cf;                                // Control-flow request expected
    logic [31:0] target;
    gpr_wr_t     wr;
    logic [31:0] pc;
} expect_t;

issued_t     issued_q[$];                           // Transferred, not yet retired
logic [31:0] shadow_gpr [32];
logic [31:0] shadow_mscratch;
logic [31:0] shadow_mtvec;
logic [31:0] shadow_mepc;

function automatic void clear_shadow();
    foreach (shadow_gpr[i]) begin
        shadow_gpr[i] = '0;
    end
    shadow_mscratch = '0;
    shadow_mtvec    = 32'h0000_0100;                // Trap vector after reset
    shadow_mepc     = '0;
endfunction

function automatic logic [31:0] read_shadow_csr(input logic [11:0] addr);
    case (addr)
        CSR_MSCRATCH: return shadow_mscratch;
        CSR_MTVEC:    return shadow_mtvec;
        CSR_MEPC:     return shadow_mepc;
        default:      return '0;                    // Unimplemented reads zero
    endcase
endfunction

function automatic void write_shadow_csr(input logic [11:0] addr, input logic [31:0] value);
    case (addr)
        CSR_MSCRATCH: shadow_mscratch = value;
        CSR_MTVEC:    shadow_mtvec    = value;
        CSR_MEPC:     shadow_mepc     = value;
        default:      ;
    endcase
endfunction

// Expected writeback of one instruction, then the state update
function automatic expect_t predict_retire(input issued_t e);
    expect_t     x;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] old;
    x       = '0;
    x.pc    = e.ins.pc;
    x.wr.rd = e.ins.rd;
    a       = shadow_gpr[e.ins.rs1];
    b       = shadow_gpr[e.ins.rs2] + e.ins.imm;    // Register plus immediate operand
    if (e.irq) begin                                // Interrupt replaces the op
        x.cf        = 1'b1;
        x.target    = shadow_mtvec;
        shadow_mepc = e.ins.pc;
    end else if (e.ins.fu[FU_ALU]) begin
        x.wr.wen = 1'b1;
        case (e.ins.uop)
            ALU_SUB: x.wr.wdata = a - b;
            ALU_AND: x.wr.wdata = a & b;
            ALU_OR:  x.wr.wdata = a | b;
            ALU_XOR: x.wr.wdata = a ^ b;
            ALU_LUI: x.wr.wdata = e.ins.imm;
            default: x.wr.wdata = a + b;
        endcase
    end else if (e.ins.fu[FU_CFU]) begin
        x.target = e.ins.pc + e.ins.imm;
        case (e.ins.uop)
            CFU_BEQ: x.cf = a == shadow_gpr[e.ins.rs2];
            CFU_BNE: x.cf = a != shadow_gpr[e.ins.rs2];
            CFU_JAL: begin
                x.cf       = 1'b1;
                x.wr.wen   = 1'b1;
                x.wr.wdata = e.ins.pc + 32'd4;      // Link value
            end
            CFU_MRET: begin
                x.cf     = 1'b1;
                x.target = shadow_mepc;
            end
            default: begin                          // ECALL and EBREAK
                x.cf        = 1'b1;
                x.target    = shadow_mtvec;
                shadow_mepc = e.ins.pc;
            end
        endcase
    end else begin                                  // CSR access, old value to rd
        old        = read_shadow_csr(e.ins.imm[11:0]);
        x.wr.wen   = e.ins.uop[CSR_READ];
        x.wr.wdata = old;
        if (e.ins.uop[CSR_WRITE]) begin
            write_shadow_csr(e.ins.imm[11:0], a);
        end else if (e.ins.uop[CSR_SET]) begin
            write_shadow_csr(e.ins.imm[11:0], old | a);
        end else if (e.ins.uop[CSR_CLEAR]) begin
            write_shadow_csr(e.ins.imm[11:0], old & ~a);
        end
    end
    if (x.wr.wen && x.wr.rd != 5'd0) begin          // x0 stays zero
        shadow_gpr[x.wr.rd] = x.wr.wdata;
    end
    return x;
endfunction

`endif

/* dv/frv_writeback_tb.sv */
// ----------------------------------------------------------
// Testbench of the back end top. Random issue stream and a
// cf_ack responder, retirements checked against the model.
// ----------------------------------------------------------
module frv_writeback_tb;
    import frv_wb_pkg::*;

    localparam int NUM_INSTR = 400;                 // Instructions per run
    localparam int TIMEOUT   = 64;                  // Cycles allowed per wait loop

    logic            g_clk = 1'b0;
    logic            g_resetn;
    logic            issue_valid;
    issue_t          issue;
    logic            irq;
    logic            issue_busy;
    logic            cf_req;
    logic [XLEN-1:0] cf_target;
    logic            cf_ack;
    gpr_wr_t         gpr_wr;
    logic            trs_valid;
    logic [XLEN-1:0] trs_pc;
    logic [31:0]     trs_instr;

    logic [31:0]     lcg_state   = 32'ha0e084f1;   // Fixed seed
    int              mismatches  = 0;
    int              failures    = 0;
    int              retired     = 0;
    logic            held_req    = 1'b0;           // Unacknowledged request last cycle
    logic [XLEN-1:0] held_target = '0;

    `include "frv_writeback_ref.svh"

    frv_writeback_top dut (
        .g_clk, .g_resetn, .issue_valid, .issue, .irq, .issue_busy,
        .cf_req, .cf_target, .cf_ack, .gpr_wr, .trs_valid, .trs_pc, .trs_instr
    );

    always #4 g_clk = ~g_clk;                       // 8 unit period

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic issued_t random_instr(input int n);
        issued_t     e;
        logic [31:0] r;
        logic [31:0] s;
        r             = next_random();
        s             = next_random();
        e             = '0;
        e.irq         = s[31:28] == 4'd0;           // Rare interrupt
        e.ins.rd      = r[4:0];
        e.ins.rs1     = r[9:5];
        e.ins.rs2     = r[24] ? r[9:5] : r[14:10];  // Equal sources now and then
        e.ins.imm     = {{24{s[7]}}, s[7:0]};
        e.ins.pc      = 32'h1000 + 32'(n) * 32'd4;
        e.ins.instr   = 32'(n);                     // Tag for the trace
        case (r[18:16])
            3'd4, 3'd5, 3'd7: begin                 // Control flow
                e.ins.fu  = 3'b010;
                e.ins.imm = {{22{s[9]}}, s[9:2], 2'b00};
                case (r[18:16])
                    3'd4:    e.ins.uop = r[20] ? CFU_BNE : CFU_BEQ;
                    3'd5:    e.ins.uop = CFU_JAL;
                    default: e.ins.uop = 5'(CFU_ECALL + r[21:20] % 3);
                endcase
            end
            3'd6: begin                             // CSR with random op flags
                e.ins.fu  = 3'b100;
                e.ins.uop = {1'b0, r[23:20]};
                e.ins.imm = r[26:25] == 2'd0 ? CSR_MTVEC :
                            r[26:25] == 2'd1 ? CSR_MEPC : CSR_MSCRATCH;
            end
            default: begin
                e.ins.fu  = 3'b001;
                e.ins.uop = 5'(r[23:20] % 6);
            end
        endcase
        return e;
    endfunction

    task automatic log_mismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        mismatches++;
    endtask

    task automatic note_failure(input string msg);
        $display("error at time %0t: %s", $time, msg);
        failures++;
    endtask

    // ----------------------------------------------------------
    // Issue stream and end of run
    // ----------------------------------------------------------
    initial begin : stimulus
        issued_t item;
        int      waited;
        g_resetn    <= 1'b0;
        issue_valid <= 1'b0;
        issue       <= '0;
        irq         <= 1'b0;
        clear_shadow();
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            item = random_instr(n);
            issue_valid <= 1'b1;
            issue       <= item.ins;
            irq         <= item.irq;                // Held with the item
            waited = 0;
            do begin
                @(negedge g_clk);
                waited++;
            end while (issue_busy && waited < TIMEOUT);
            if (issue_busy) begin
                note_failure("issue_busy never dropped, instruction not accepted");
                break;
            end
            @(posedge g_clk);
            issued_q.push_back(item);               // Transferred at this edge
            if (next_random() % 4 == 0) begin       // Idle gap
                issue_valid <= 1'b0;
                @(posedge g_clk);
            end
        end
        issue_valid <= 1'b0;
        waited = 0;
        while (issued_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge g_clk);
            waited++;
        end
        if (issued_q.size() != 0) begin
            note_failure("issued instructions never retired");
        end
        if (retired != NUM_INSTR) begin
            note_failure($sformatf("%0d instructions retired, %0d issued", retired, NUM_INSTR));
        end
        $display("summary: %0d mismatches, %0d other errors, %0d retired",
                 mismatches, failures, retired);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Fetch side acknowledges after a random delay
    initial begin : responder
        int delay;
        cf_ack <= 1'b0;
        forever begin
            @(negedge g_clk);
            if (g_resetn && cf_req && !cf_ack) begin
                delay = next_random() % 4;
                repeat (delay) @(posedge g_clk);
                @(posedge g_clk);
                cf_ack <= 1'b1;
                @(posedge g_clk);
                cf_ack <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // Compare at the falling edge, outputs settled
    // ----------------------------------------------------------
    always @(negedge g_clk) begin : compare
        issued_t head;
        expect_t want;
        if (g_resetn) begin
            if (held_req && (!cf_req || cf_target != held_target)) begin
                note_failure("cf_req dropped or cf_target moved before cf_ack");
            end
            held_req    = cf_req && !cf_ack;
            held_target = cf_target;
            if (gpr_wr.wen && !trs_valid) begin
                note_failure("GPR write enable high with no instruction retiring");
            end
            if (trs_valid && issued_q.size() == 0) begin
                note_failure("an instruction retired that was never issued");
            end else if (trs_valid) begin
                head = issued_q.pop_front();
                want = predict_retire(head);
                retired++;
                if (trs_pc != want.pc || trs_instr != head.ins.instr) begin
                    log_mismatch($sformatf("trace pc %h instr %h, expected pc %h instr %h",
                                           trs_pc, trs_instr, want.pc, head.ins.instr));
                end
                if (gpr_wr.wen != want.wr.wen || (want.wr.wen &&
                    (gpr_wr.rd != want.wr.rd || gpr_wr.wdata != want.wr.wdata))) begin
                    log_mismatch($sformatf("pc %h GPR write %b x%0d=%h, expected %b x%0d=%h",
                                           want.pc, gpr_wr.wen, gpr_wr.rd, gpr_wr.wdata,
                                           want.wr.wen, want.wr.rd, want.wr.wdata));
                end
                if (cf_req != want.cf || (want.cf && (!cf_ack || cf_target != want.target))) begin
                    log_mismatch($sformatf("pc %h cf_req %b ack %b target %h, expected %b %h",
                                           want.pc, cf_req, cf_ack, cf_target,
                                           want.cf, want.target));
                end
            end else if (cf_req && issued_q.size() == 0) begin
                note_failure("cf_req raised with no instruction in flight");
            end
        end
    end

endmodule

/* frv_writeback.f */
+incdir+dv
src/frv_wb_pkg.sv
src/frv_gpr_regfile.sv
src/frv_csr_regfile.sv
src/frv_pipeline_execute.sv
src/frv_pipeline_register.sv
src/frv_pipeline_writeback.sv
src/frv_writeback_top.sv
dv/frv_writeback_tb.sv

/* src/frv_csr_regfile.sv */
// ----------------------------------------------------------
// Machine CSRs mscratch, mtvec and mepc. Serves writeback
// accesses and captures mepc on a trap.
// ----------------------------------------------------------
module frv_csr_regfile (
    input  logic                          g_clk,       // Global clock
    input  logic                          g_resetn,    // Sync reset, active low
    input  frv_wb_pkg::csr_req_t          req,
    output logic [frv_wb_pkg::XLEN-1:0]   rdata,       // Value before this access
    input  frv_wb_pkg::trap_t             trap,
    output logic [frv_wb_pkg::XLEN-1:0]   mtvec,
    output logic [frv_wb_pkg::XLEN-1:0]   mepc
);
    import frv_wb_pkg::*;

    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] wr_value;
    logic            do_write;

    // Read select, unknown addresses give zero
    always_comb begin
        case (req.addr)
            CSR_MSCRATCH: rdata = mscratch_q;
            CSR_MTVEC:    rdata = mtvec_q;
            CSR_MEPC:     rdata = mepc_q;
            default:      rdata = '0;
        endcase
    end

    // Write beats set, set beats clear
    always_comb begin
        if (req.wr) begin
            wr_value = req.wdata;
        end else if (req.set) begin
            wr_value = rdata | req.wdata;
        end else begin
            wr_value = rdata & ~req.wdata;
        end
    end

    assign do_write = req.en && (req.wr || req.set || req.clr);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch_q <= '0;
            mtvec_q    <= MTVEC_RESET;
            mepc_q     <= '0;
        end else begin
            if (do_write && req.addr == CSR_MSCRATCH) begin
                mscratch_q <= wr_value;
            end
            if (do_write && req.addr == CSR_MTVEC) begin
                mtvec_q <= wr_value;
            end
            if (trap.valid) begin
                mepc_q <= trap.pc;                       // Trap wins over a CSR write
            end else if (do_write && req.addr == CSR_MEPC) begin
                mepc_q <= wr_value;
            end
        end
    end

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

endmodule

/* src/frv_gpr_regfile.sv */
// ----------------------------------------------------------
// General purpose registers. Two read ports, one write port,
// x0 reads as zero.
// ----------------------------------------------------------
module frv_gpr_regfile (
    input  logic                          g_clk,       // Global clock
    input  logic                          g_resetn,    // Sync reset, active low
    input  logic [4:0]                    rs1_addr,
    input  logic [4:0]                    rs2_addr,
    output logic [frv_wb_pkg::XLEN-1:0]   rs1_data,    // Asynchronous read
    output logic [frv_wb_pkg::XLEN-1:0]   rs2_data,
    input  frv_wb_pkg::gpr_wr_t           wr
);
    import frv_wb_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.wen && wr.rd != 5'd0) begin    // x0 never written
            regs[wr.rd] <= wr.wdata;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* src/frv_pipeline_execute.sv */
// ----------------------------------------------------------
// Execute stage. Reads operands with forwarding, resolves ALU
// and branch work and builds the writeback item, all combinational.
// ----------------------------------------------------------
module frv_pipeline_execute (
    input  logic                          g_clk,        // Global clock
    input  logic                          g_resetn,     // Sync reset, active low
    input  logic                          issue_valid,  // Issue offer
    input  frv_wb_pkg::issue_t            issue,        // Held while busy
    input  logic                          irq,          // Sampled with the item
    output logic                          issue_busy,
    output logic [4:0]                    rs1_addr,
    output logic [4:0]                    rs2_addr,
    input  logic [frv_wb_pkg::XLEN-1:0]   rs1_data,
    input  logic [frv_wb_pkg::XLEN-1:0]   rs2_data,
    input  frv_wb_pkg::gpr_wr_t           fwd,          // Writeback write port
    output logic                          s3_valid,
    output frv_wb_pkg::wb_item_t          s3_item,
    input  logic                          s3_busy
);
    import frv_wb_pkg::*;

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] target;
    logic            is_branch;
    logic            taken;

    assign rs1_addr   = issue.rs1;
    assign rs2_addr   = issue.rs2;
    assign s3_valid   = issue_valid;                    // No work of its own to stall
    assign issue_busy = s3_busy;

    // ----------------------------------------------------------
    // Operand fetch
    // ----------------------------------------------------------
    assign rs1_val = (fwd.wen && fwd.rd != 5'd0 && fwd.rd == issue.rs1) ? fwd.wdata : rs1_data;
    assign rs2_val = (fwd.wen && fwd.rd != 5'd0 && fwd.rd == issue.rs2) ? fwd.wdata : rs2_data;

    // rs2 = x0 gives the immediate form
    assign alu_b = rs2_val + issue.imm;

    always_comb begin
        case (issue.uop)
            ALU_SUB: alu_result = rs1_val - alu_b;
            ALU_AND: alu_result = rs1_val & alu_b;
            ALU_OR:  alu_result = rs1_val | alu_b;
            ALU_XOR: alu_result = rs1_val ^ alu_b;
            ALU_LUI: alu_result = issue.imm;            // Immediate passes through
            default: alu_result = rs1_val + alu_b;      // ALU_ADD
        endcase
    end

    // ----------------------------------------------------------
    // Branch resolution
    // ----------------------------------------------------------
    assign is_branch = issue.uop == CFU_BEQ || issue.uop == CFU_BNE;
    assign taken     = (issue.uop == CFU_BEQ && rs1_val == rs2_val) ||
                       (issue.uop == CFU_BNE && rs1_val != rs2_val);
    assign target    = issue.pc + issue.imm;            // Branch and JAL target

    always_comb begin
        s3_item.fu    = issue.fu;
        s3_item.uop   = issue.uop;
        s3_item.rd    = issue.rd;
        s3_item.opr_a = alu_result;
        s3_item.opr_b = alu_b;
        s3_item.pc    = issue.pc;
        s3_item.instr = issue.instr;
        s3_item.trap  = irq;                            // Turns the item into an interrupt
        if (issue.fu[FU_CFU]) begin
            s3_item.opr_a = target;
            s3_item.opr_b = issue.pc + 32'd4;           // Link value
            if (is_branch && !taken) begin
                s3_item.uop = CFU_NOT_TAKEN;
            end
            if (issue.uop == CFU_JAL) begin
                s3_item.fu[FU_ALU] = 1'b1;              // Link goes through the ALU path
            end
        end else if (issue.fu[FU_CSR]) begin
            s3_item.opr_a = rs1_val;
            s3_item.opr_b = {{(XLEN-12){1'b0}}, issue.imm[11:0]};  // CSR address
        end
    end

    // Item must not move while the register refuses it
    // Forwarded operands may update it in the cycle it is taken
    a_item_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s3_valid && s3_busy |=> s3_valid && (!s3_busy || $stable(s3_item)));

endmodule

/* src/frv_pipeline_register.sv */
// ----------------------------------------------------------
// One-entry pipeline register with valid/busy flow control.
// The payload type is set per instance.
// ----------------------------------------------------------
module frv_pipeline_register #(
    parameter type payload_t = logic
) (
    input  logic     g_clk,                 // Global clock
    input  logic     g_resetn,              // Sync reset, active low
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_busy,               // Full and not draining
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_busy
);

    logic     valid_q;
    payload_t data_q;                       // Payload, no reset
    logic     accept;
    logic     drain;

    assign drain    = valid_q && !out_busy; // Consumer takes it this cycle
    assign in_busy  = valid_q && out_busy;
    assign accept   = in_valid && !in_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    a_out_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        out_valid && out_busy |=> out_valid && $stable(out_data));

endmodule

/* src/frv_pipeline_writeback.sv */
// ----------------------------------------------------------
// Writeback stage. Retires each item: GPR write, CSR access,
// control-flow requests, trap capture and the trace port.
// ----------------------------------------------------------
module frv_pipeline_writeback (
    input  logic                          g_clk,        // Global clock
    input  logic                          g_resetn,     // Sync reset, active low
    input  logic                          s4_valid,
    input  frv_wb_pkg::wb_item_t          s4_item,
    output logic                          s4_busy,      // Stalled on cf_ack
    output frv_wb_pkg::gpr_wr_t           gpr_wr,       // Also the forwarding path
    output frv_wb_pkg::csr_req_t          csr_req,
    input  logic [frv_wb_pkg::XLEN-1:0]   csr_rdata,    // Old value of csr_req.addr
    input  logic [frv_wb_pkg::XLEN-1:0]   csr_mtvec,
    input  logic [frv_wb_pkg::XLEN-1:0]   csr_mepc,
    output frv_wb_pkg::trap_t             trap,
    output logic                          cf_req,       // Level, held until cf_ack
    output logic [frv_wb_pkg::XLEN-1:0]   cf_target,
    input  logic                          cf_ack,
    output logic                          trs_valid,
    output logic [frv_wb_pkg::XLEN-1:0]   trs_pc,
    output logic [31:0]                   trs_instr
);
    import frv_wb_pkg::*;

    logic fu_alu;
    logic fu_cfu;
    logic fu_csr;
    logic pipe_progress;
    logic cfu_taken;
    logic cfu_trap;
    logic cfu_mret;
    logic tgt_trap;
    logic alu_gpr_wen;
    logic csr_gpr_wen;

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    assign fu_alu = s4_item.fu[FU_ALU] && !s4_item.trap;   // Interrupt kills the op
    assign fu_cfu = s4_item.fu[FU_CFU] && !s4_item.trap;
    assign fu_csr = s4_item.fu[FU_CSR] && !s4_item.trap;

    assign pipe_progress = s4_valid && !s4_busy;

    // ----------------------------------------------------------
    // Control flow
    // ----------------------------------------------------------
    assign cfu_taken = fu_cfu && (s4_item.uop == CFU_BEQ || s4_item.uop == CFU_BNE ||
                                  s4_item.uop == CFU_JAL);
    assign cfu_trap  = fu_cfu && (s4_item.uop == CFU_ECALL || s4_item.uop == CFU_EBREAK);
    assign cfu_mret  = fu_cfu && s4_item.uop == CFU_MRET;
    assign tgt_trap  = cfu_trap || s4_item.trap;            // Vector through mtvec

    assign cf_req = s4_valid && (cfu_taken || tgt_trap || cfu_mret);

    always_comb begin
        if (tgt_trap) begin
            cf_target = csr_mtvec;
        end else if (cfu_mret) begin
            cf_target = csr_mepc;
        end else begin
            cf_target = s4_item.opr_a;                      // Branch or JAL target
        end
    end

    assign s4_busy = cf_req && !cf_ack;                     // Wait for fetch side

    // ----------------------------------------------------------
    // CSR access
    // ----------------------------------------------------------
    assign csr_req.en    = pipe_progress && fu_csr;
    assign csr_req.wr    = fu_csr && s4_item.uop[CSR_WRITE];
    assign csr_req.set   = fu_csr && s4_item.uop[CSR_SET];
    assign csr_req.clr   = fu_csr && s4_item.uop[CSR_CLEAR];
    assign csr_req.addr  = s4_item.opr_b[11:0];
    assign csr_req.wdata = s4_item.opr_a;

    // ----------------------------------------------------------
    // GPR writeback
    // ----------------------------------------------------------
    assign alu_gpr_wen = fu_alu;                            // Includes JAL link
    assign csr_gpr_wen = fu_csr && s4_item.uop[CSR_READ];

    assign gpr_wr.wen = pipe_progress && (alu_gpr_wen || csr_gpr_wen);
    assign gpr_wr.rd  = s4_item.rd;

    always_comb begin
        if (csr_gpr_wen) begin
            gpr_wr.wdata = csr_rdata;
        end else if (fu_cfu) begin
            gpr_wr.wdata = s4_item.opr_b;                   // JAL return address
        end else begin
            gpr_wr.wdata = s4_item.opr_a;
        end
    end

    // ----------------------------------------------------------
    // Trap capture and trace
    // ----------------------------------------------------------
    assign trap.valid = pipe_progress && tgt_trap;
    assign trap.pc    = s4_item.pc;                         // Lands in mepc

    assign trs_valid = pipe_progress;
    assign trs_pc    = s4_item.pc;
    assign trs_instr = s4_item.instr;

    a_cf_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> cf_req && $stable(cf_target));

endmodule

/* src/frv_wb_pkg.sv */
// ----------------------------------------------------------
// Shared widths, opcodes and bundles of the RV32 back end.
// Modules import it inside their body.
// ----------------------------------------------------------
package frv_wb_pkg;

    localparam int XLEN = 32;                          // Data path width

    // Functional unit bit positions
    localparam int FU_ALU = 0;
    localparam int FU_CFU = 1;
    localparam int FU_CSR = 2;

    // ALU micro-ops
    localparam logic [4:0] ALU_ADD = 5'd0;
    localparam logic [4:0] ALU_SUB = 5'd1;
    localparam logic [4:0] ALU_AND = 5'd2;
    localparam logic [4:0] ALU_OR  = 5'd3;
    localparam logic [4:0] ALU_XOR = 5'd4;
    localparam logic [4:0] ALU_LUI = 5'd5;

    // CFU micro-ops
    localparam logic [4:0] CFU_BEQ       = 5'd0;
    localparam logic [4:0] CFU_BNE       = 5'd1;
    localparam logic [4:0] CFU_JAL       = 5'd2;
    localparam logic [4:0] CFU_ECALL     = 5'd3;
    localparam logic [4:0] CFU_EBREAK    = 5'd4;
    localparam logic [4:0] CFU_MRET      = 5'd5;
    localparam logic [4:0] CFU_NOT_TAKEN = 5'd6;     // Branch resolved not taken

    // CSR micro-op flag bits
    localparam int CSR_READ  = 0;
    localparam int CSR_WRITE = 1;
    localparam int CSR_SET   = 2;
    localparam int CSR_CLEAR = 3;

    // Implemented machine CSRs
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100;

    typedef struct packed {
        logic [2:0]      fu;                           // One-hot unit select
        logic [4:0]      uop;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [31:0]     imm;
        logic [31:0]     pc;
        logic [31:0]     instr;
    } issue_t;

    typedef struct packed {
        logic [2:0]      fu;
        logic [4:0]      uop;
        logic [4:0]      rd;
        logic [XLEN-1:0] opr_a;                        // Result, target or CSR data
        logic [XLEN-1:0] opr_b;                        // Link value or CSR address
        logic [31:0]     pc;
        logic [31:0]     instr;
        logic            trap;                         // Interrupt taken on this item
    } wb_item_t;

    typedef struct packed {
        logic            wen;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
    } gpr_wr_t;

    typedef struct packed {
        logic            en;
        logic            wr;
        logic            set;
        logic            clr;
        logic [11:0]     addr;
        logic [XLEN-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic            valid;
        logic [31:0]     pc;
    } trap_t;

endpackage

/* src/frv_writeback_top.sv */
// ----------------------------------------------------------
// Back end top. Execute, stage register and writeback with the
// GPR and CSR files; exposes issue, control flow and trace.
// ----------------------------------------------------------
module frv_writeback_top (
    input  logic                          g_clk,        // Global clock
    input  logic                          g_resetn,     // Sync reset, active low
    input  logic                          issue_valid,
    input  frv_wb_pkg::issue_t            issue,
    input  logic                          irq,
    output logic                          issue_busy,
    output logic                          cf_req,
    output logic [frv_wb_pkg::XLEN-1:0]   cf_target,
    input  logic                          cf_ack,
    output frv_wb_pkg::gpr_wr_t           gpr_wr,       // Observed write port
    output logic                          trs_valid,
    output logic [frv_wb_pkg::XLEN-1:0]   trs_pc,
    output logic [31:0]                   trs_instr
);
    import frv_wb_pkg::*;

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            s3_valid;
    logic            s3_busy;
    wb_item_t        s3_item;
    logic            s4_valid;
    logic            s4_busy;
    wb_item_t        s4_item;
    csr_req_t        csr_req;
    logic [XLEN-1:0] csr_rdata;
    logic [XLEN-1:0] csr_mtvec;
    logic [XLEN-1:0] csr_mepc;
    trap_t           trap;

    frv_pipeline_execute u_execute (
        .g_clk, .g_resetn, .issue_valid, .issue, .irq, .issue_busy,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .fwd      (gpr_wr),                             // Writeback forwarding
        .s3_valid, .s3_item, .s3_busy
    );

    frv_pipeline_register #(.payload_t(wb_item_t)) u_s4_reg (
        .g_clk, .g_resetn,
        .in_valid  (s3_valid), .in_data  (s3_item), .in_busy  (s3_busy),
        .out_valid (s4_valid), .out_data (s4_item), .out_busy (s4_busy)
    );

    frv_pipeline_writeback u_writeback (
        .g_clk, .g_resetn, .s4_valid, .s4_item, .s4_busy, .gpr_wr,
        .csr_req, .csr_rdata, .csr_mtvec, .csr_mepc, .trap,
        .cf_req, .cf_target, .cf_ack, .trs_valid, .trs_pc, .trs_instr
    );

    frv_gpr_regfile u_gpr (
        .g_clk, .g_resetn, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wr (gpr_wr)
    );

    frv_csr_regfile u_csr (
        .g_clk, .g_resetn, .req (csr_req), .rdata (csr_rdata), .trap,
        .mtvec (csr_mtvec), .mepc (csr_mepc)
    );

endmodule
